/* src/rv_core_pkg.sv */
package rv_core_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Architectural register count, x0 included
    localparam int REG_COUNT = 32;

    // One register value
    typedef logic [XLEN-1:0] reg_data_t;

    // Register index, enough for REG_COUNT entries
    typedef logic [$clog2(REG_COUNT)-1:0] reg_index_t;

    // Instruction word or byte address
    typedef logic [XLEN-1:0] word_t;

    // Instruction field types
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Major opcodes that the core executes
    localparam opcode_t OPCODE_R_TYPE = 7'b0110011;
    localparam opcode_t OPCODE_IMM    = 7'b0010011;

    // funct3 per operation, shared by R-type and I-type forms
    localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
    localparam funct3_t FUNCT3_SLL     = 3'b001;
    localparam funct3_t FUNCT3_SLT     = 3'b010;
    localparam funct3_t FUNCT3_SLTU    = 3'b011;
    localparam funct3_t FUNCT3_XOR     = 3'b100;
    localparam funct3_t FUNCT3_SRL_SRA = 3'b101;
    localparam funct3_t FUNCT3_OR      = 3'b110;
    localparam funct3_t FUNCT3_AND     = 3'b111;

    // funct7, also imm[11:5] of the shift immediates
    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    // Selects SUB, SRA and SRAI
    localparam funct7_t FUNCT7_ALT  = 7'b0100000;

    // ALU operations; I-type forms reuse these with the immediate
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_t;

    // Decoder output, held through EXECUTE
    typedef struct packed {
        // Set only for the supported R/I-type operations
        logic       legal;
        // Second operand comes from imm instead of rs2
        logic       use_imm;
        alu_op_t    alu_op;
        reg_index_t rs1;
        reg_index_t rs2;
        reg_index_t rd;
        // Sign-extended I immediate, shift amount in [4:0]
        reg_data_t  imm;
    } decoded_t;

    // Instruction memory request
    typedef struct packed {
        word_t addr;
    } imem_req_t;

    // Instruction memory response
    typedef struct packed {
        word_t data;
    } imem_rsp_t;

    // Writeback report, same values as the register file write
    typedef struct packed {
        word_t      pc;
        reg_index_t rd;
        reg_data_t  data;
    } commit_t;

endpackage

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_fetch_en,
    input  logic                   i_advance,
    output logic                   o_imem_req_valid,
    input  logic                   i_imem_req_ready,
    output rv_core_pkg::imem_req_t o_imem_req,
    input  logic                   i_imem_rsp_valid,
    input  rv_core_pkg::imem_rsp_t i_imem_rsp,
    output logic                   o_instr_valid,
    output rv_core_pkg::word_t     o_instr,
    output rv_core_pkg::word_t     o_pc
);
    import rv_core_pkg::*;

    word_t pc;
    // High from request acceptance until the response arrives
    logic  req_sent;
    word_t instr_q;

    // One request per FETCH, raised in its first cycle
    assign o_imem_req_valid = i_fetch_en && !req_sent;
    assign o_imem_req       = '{addr: pc};

    // Response pulse; only meaningful with a request in flight
    assign o_instr_valid = req_sent && i_imem_rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= RESET_PC;
            req_sent <= 1'b0;
        end else begin
            // Sequential PC only, no control flow kept
            if (i_advance) begin
                pc <= pc + 32'd4;
            end
            if (o_imem_req_valid && i_imem_req_ready) begin
                req_sent <= 1'b1;
            end else if (o_instr_valid) begin
                req_sent <= 1'b0;
            end
        end
    end

    // Instruction register, valid from DECODE on
    always_ff @(posedge clk) begin
        if (o_instr_valid) begin
            instr_q <= i_imem_rsp.data;
        end
    end

    assign o_instr = instr_q;
    assign o_pc    = pc;

    // Stalled request keeps valid up and the address frozen
    assert property (@(posedge clk) disable iff (reset)
        (o_imem_req_valid && !i_imem_req_ready) |=> (o_imem_req_valid && $stable(o_imem_req.addr)))
        else $error("imem request dropped or changed while stalled");

endmodule

/* src/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  rv_core_pkg::word_t    i_instr,
    output rv_core_pkg::decoded_t o_dec
);
    import rv_core_pkg::*;

    opcode_t opcode;
    funct3_t funct3;
    funct7_t funct7;
    // Same bits as funct7, named for the shift immediates
    funct7_t imm_hi;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign imm_hi = i_instr[31:25];

    always_comb begin
        o_dec = '0;
        // Fields are extracted for every encoding, legal or not
        o_dec.rs1 = i_instr[19:15];
        o_dec.rs2 = i_instr[24:20];
        o_dec.rd  = i_instr[11:7];
        // I immediate; shamt lands in [4:0] on its own
        o_dec.imm    = {{20{i_instr[31]}}, i_instr[31:20]};
        o_dec.alu_op = ALU_ADD;

        case (opcode)
            OPCODE_R_TYPE: begin
                o_dec.use_imm = 1'b0;
                // Only ADD/SUB and SRL/SRA accept the alternate funct7
                case (funct3)
                    FUNCT3_ADD_SUB: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                        o_dec.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
                    end
                    FUNCT3_SRL_SRA: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                        o_dec.alu_op = (funct7 == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                    end
                    FUNCT3_SLL: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE);
                        o_dec.alu_op = ALU_SLL;
                    end
                    FUNCT3_SLT: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE);
                        o_dec.alu_op = ALU_SLT;
                    end
                    FUNCT3_SLTU: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE);
                        o_dec.alu_op = ALU_SLTU;
                    end
                    FUNCT3_XOR: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE);
                        o_dec.alu_op = ALU_XOR;
                    end
                    FUNCT3_OR: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE);
                        o_dec.alu_op = ALU_OR;
                    end
                    default: begin
                        o_dec.legal  = (funct7 == FUNCT7_BASE);
                        o_dec.alu_op = ALU_AND;
                    end
                endcase
            end
            OPCODE_IMM: begin
                o_dec.use_imm = 1'b1;
                o_dec.legal   = 1'b1;
                case (funct3)
                    FUNCT3_ADD_SUB: o_dec.alu_op = ALU_ADD;
                    FUNCT3_SLT:     o_dec.alu_op = ALU_SLT;
                    FUNCT3_SLTU:    o_dec.alu_op = ALU_SLTU;
                    FUNCT3_XOR:     o_dec.alu_op = ALU_XOR;
                    FUNCT3_OR:      o_dec.alu_op = ALU_OR;
                    FUNCT3_AND:     o_dec.alu_op = ALU_AND;
                    // Shifts constrain imm[11:5]
                    FUNCT3_SLL: begin
                        o_dec.legal  = (imm_hi == FUNCT7_BASE);
                        o_dec.alu_op = ALU_SLL;
                    end
                    default: begin
                        o_dec.legal  = (imm_hi == FUNCT7_BASE) || (imm_hi == FUNCT7_ALT);
                        o_dec.alu_op = (imm_hi == FUNCT7_ALT) ? ALU_SRA : ALU_SRL;
                    end
                endcase
            end
            // Everything else retires without a write
            default: o_dec.legal = 1'b0;
        endcase
    end

    // Legal implies one of the two executed opcodes
    always_comb begin
        if (o_dec.legal) begin
            assert (opcode == OPCODE_R_TYPE || opcode == OPCODE_IMM)
                else $error("legal flag set for opcode %b", opcode);
        end
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::reg_index_t i_rs1,
    input  rv_core_pkg::reg_index_t i_rs2,
    output rv_core_pkg::reg_data_t  o_rs1_data,
    output rv_core_pkg::reg_data_t  o_rs2_data,
    input  logic                   i_we,
    input  rv_core_pkg::reg_index_t i_rd,
    input  rv_core_pkg::reg_data_t  i_wdata
);
    import rv_core_pkg::*;

    reg_data_t regs [REG_COUNT];

    // Write port, x0 never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_rd != '0) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // Synchronous reads, data one cycle after the address
    always_ff @(posedge clk) begin
        o_rs1_data <= (i_rs1 == '0) ? '0 : regs[i_rs1];
        o_rs2_data <= (i_rs2 == '0) ? '0 : regs[i_rs2];
    end

    // x0 stays zero whatever the write port sees
    assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_core_pkg::alu_op_t   i_op,
    input  logic                   i_use_imm,
    input  rv_core_pkg::reg_data_t i_rs1_data,
    input  rv_core_pkg::reg_data_t i_rs2_data,
    input  rv_core_pkg::reg_data_t i_imm,
    output rv_core_pkg::reg_data_t o_result
);
    import rv_core_pkg::*;

    reg_data_t  operand_b;
    // Shifts use only the low 5 bits, for both rs2 and shamt
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign operand_b   = i_use_imm ? i_imm : i_rs2_data;
    assign shamt       = operand_b[4:0];
    assign lt_signed   = $signed(i_rs1_data) < $signed(operand_b);
    // SLTIU compares against the sign-extended immediate as unsigned
    assign lt_unsigned = i_rs1_data < operand_b;

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_rs1_data + operand_b;
            ALU_SUB:  o_result = i_rs1_data - operand_b;
            ALU_AND:  o_result = i_rs1_data & operand_b;
            ALU_OR:   o_result = i_rs1_data | operand_b;
            ALU_XOR:  o_result = i_rs1_data ^ operand_b;
            ALU_SLL:  o_result = i_rs1_data << shamt;
            ALU_SRL:  o_result = i_rs1_data >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  o_result = reg_data_t'($signed(i_rs1_data) >>> shamt);
            // Compares give 0 or 1
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  o_result = '0;
        endcase
    end

endmodule

/* src/rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   o_imem_req_valid,
    input  logic                   i_imem_req_ready,
    output rv_core_pkg::imem_req_t o_imem_req,
    input  logic                   i_imem_rsp_valid,
    input  rv_core_pkg::imem_rsp_t i_imem_rsp,
    output logic                   o_commit_valid,
    output rv_core_pkg::commit_t   o_commit
);
    import rv_core_pkg::*;

    // Idle only for the first cycle out of reset
    typedef enum logic [2:0] {
        STAGE_IDLE,
        STAGE_FETCH,
        STAGE_DECODE,
        STAGE_EXECUTE,
        STAGE_WRITEBACK
    } stage_t;

    stage_t    stage;
    logic      instr_valid;
    word_t     instr;
    word_t     pc;
    decoded_t  dec;
    decoded_t  dec_q;
    reg_data_t rs1_data;
    reg_data_t rs2_data;
    reg_data_t alu_result;
    // WRITEBACK holding registers
    logic       wb_legal;
    reg_index_t wb_rd;
    reg_data_t  wb_data;
    logic       wb_fire;

    fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
        .clk, .reset,
        .i_fetch_en(stage == STAGE_FETCH),
        .i_advance(stage == STAGE_WRITEBACK),
        .o_imem_req_valid, .i_imem_req_ready, .o_imem_req,
        .i_imem_rsp_valid, .i_imem_rsp,
        .o_instr_valid(instr_valid), .o_instr(instr), .o_pc(pc)
    );

    instr_decoder i_decoder (.i_instr(instr), .o_dec(dec));

    // Addresses come straight from decode, data lands in EXECUTE
    register_file i_regs (
        .clk, .reset,
        .i_rs1(dec.rs1), .i_rs2(dec.rs2),
        .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
        .i_we(wb_fire), .i_rd(wb_rd), .i_wdata(wb_data)
    );

    alu i_alu (
        .i_op(dec_q.alu_op), .i_use_imm(dec_q.use_imm),
        .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(dec_q.imm),
        .o_result(alu_result)
    );

    // Stage sequencer; FETCH waits on the response
    always_ff @(posedge clk) begin
        if (reset) begin
            stage    <= STAGE_IDLE;
            wb_legal <= 1'b0;
        end else begin
            case (stage)
                STAGE_IDLE:    stage <= STAGE_FETCH;
                STAGE_FETCH:   stage <= instr_valid ? STAGE_DECODE : STAGE_FETCH;
                STAGE_DECODE:  stage <= STAGE_EXECUTE;
                STAGE_EXECUTE: stage <= STAGE_WRITEBACK;
                default:       stage <= STAGE_FETCH;
            endcase
            if (stage == STAGE_EXECUTE) begin
                wb_legal <= dec_q.legal;
            end
        end
    end

    // Payload registers between stages
    always_ff @(posedge clk) begin
        if (stage == STAGE_DECODE) begin
            dec_q <= dec;
        end
        if (stage == STAGE_EXECUTE) begin
            wb_rd   <= dec_q.rd;
            wb_data <= alu_result;
        end
    end

    // Illegal encodings reach WRITEBACK but write nothing
    assign wb_fire = (stage == STAGE_WRITEBACK) && wb_legal;

    // PC not yet advanced in WRITEBACK
    assign o_commit_valid = wb_fire;
    assign o_commit       = '{pc: pc, rd: wb_rd, data: wb_data};

    // Result consumed in EXECUTE always comes from a defined op
    assert property (@(posedge clk) disable iff (reset)
        (stage == STAGE_EXECUTE) |-> (dec_q.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND,
            ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU}))
        else $error("undefined ALU op in EXECUTE");

endmodule

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected outcome of one instruction
typedef struct packed {
    logic    legal;
    commit_t commit;
} expect_t;

// Instruction together with the address it was served from
typedef struct packed {
    word_t pc;
    word_t instr;
} fetch_t;

// Architectural registers, x0 never written
reg_data_t ref_regs [REG_COUNT];

function automatic void clear_ref_regs();
    for (int i = 0; i < REG_COUNT; i++) begin
        ref_regs[i] = '0;
    end
endfunction

// Executes one instruction per the RV32I rules and updates ref_regs
function automatic expect_t ref_execute(input word_t instr, input word_t pc);
    expect_t    res;
    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       is_r;
    logic       alt;
    reg_data_t  a;
    reg_data_t  b;
    reg_data_t  value;

    opcode = instr[6:0];
    f3     = instr[14:12];
    f7     = instr[31:25];
    is_r   = (opcode == OPCODE_R_TYPE);
    // Also imm[11:5] for the I-type shifts
    alt    = (f7 == FUNCT7_ALT);
    a      = ref_regs[instr[19:15]];
    b      = is_r ? ref_regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
    res    = '0;

    // Only SUB, SRA and SRAI take the alternate funct7
    if (is_r) begin
        res.legal = (f7 == FUNCT7_BASE) || (alt && (f3 == 3'b000 || f3 == 3'b101));
    end else if (opcode == OPCODE_IMM) begin
        res.legal = (f3 == 3'b001) ? (f7 == FUNCT7_BASE) :
                    (f3 == 3'b101) ? (f7 == FUNCT7_BASE || alt) : 1'b1;
    end

    case (f3)
        // ADDI ignores the top immediate bits
        3'b000:  value = (is_r && alt) ? a - b : a + b;
        3'b001:  value = a << b[4:0];
        3'b010:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  value = (a < b) ? 32'd1 : 32'd0;
        3'b100:  value = a ^ b;
        3'b101:  value = alt ? reg_data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  value = a | b;
        default: value = a & b;
    endcase

    if (res.legal) begin
        res.commit = '{pc: pc, rd: instr[11:7], data: value};
        // x0 reports the value but keeps zero
        if (instr[11:7] != 5'd0) begin
            ref_regs[instr[11:7]] = value;
        end
    end
    return res;
endfunction

`endif

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam word_t RESET_PC    = 32'h0000_1000;
    localparam int    INSTR_COUNT = 2000;
    // Longest wait on any handshake
    localparam int    WAIT_LIMIT  = 64;

    logic      clk = 1'b0;
    logic      reset;
    logic      imem_req_valid;
    logic      imem_req_ready;
    imem_req_t imem_req;
    logic      imem_rsp_valid;
    imem_rsp_t imem_rsp;
    logic      commit_valid;
    commit_t   commit;

    `include "tb_ref_model.svh"

    // Monitor state
    fetch_t      fetch_q [$];
    fetch_t      served;
    expect_t     expected;
    logic        pending = 1'b0;
    int unsigned due_cycle = 0;
    int unsigned cycle_count = 0;
    int unsigned commit_count = 0;

    rv_core #(.RESET_PC(RESET_PC)) i_dut (
        .clk, .reset,
        .o_imem_req_valid(imem_req_valid), .i_imem_req_ready(imem_req_ready),
        .o_imem_req(imem_req),
        .i_imem_rsp_valid(imem_rsp_valid), .i_imem_rsp(imem_rsp),
        .o_commit_valid(commit_valid), .o_commit(commit)
    );

    always #2 clk = ~clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at first error");
    endtask

    // x0 about one time in eight
    function automatic reg_index_t pick_reg();
        if ($urandom_range(0, 7) == 0) begin
            return '0;
        end
        return reg_index_t'($urandom_range(1, 31));
    endfunction

    function automatic word_t make_instr();
        word_t       instr;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        int unsigned kind;
        kind = $urandom_range(0, 99);
        f3   = 3'($urandom_range(0, 7));
        imm  = 12'($urandom);
        f7   = ($urandom_range(0, 1) == 1) ? FUNCT7_ALT : FUNCT7_BASE;
        if (kind < 40) begin
            // Alternate funct7 only where the ISA has it
            if (f3 != FUNCT3_ADD_SUB && f3 != FUNCT3_SRL_SRA) begin
                f7 = FUNCT7_BASE;
            end
            instr = {f7, pick_reg(), pick_reg(), f3, pick_reg(), OPCODE_R_TYPE};
        end else if (kind < 80) begin
            // Shift immediates carry funct7 in imm[11:5]
            if (f3 == FUNCT3_SLL) begin
                imm[11:5] = FUNCT7_BASE;
            end else if (f3 == FUNCT3_SRL_SRA) begin
                imm[11:5] = f7;
            end
            instr = {imm, pick_reg(), f3, pick_reg(), OPCODE_IMM};
        end else begin
            case ($urandom_range(0, 4))
                // LW
                0: instr = {imm, pick_reg(), 3'b010, pick_reg(), 7'b0000011};
                // BEQ
                1: instr = {7'($urandom), pick_reg(), pick_reg(), 3'b000,
                            5'($urandom), 7'b1100011};
                // M-extension funct7
                2: instr = {7'b0000001, pick_reg(), pick_reg(), f3, pick_reg(), OPCODE_R_TYPE};
                // SLLI with SRAI's funct7
                3: instr = {FUNCT7_ALT, 5'($urandom), pick_reg(), FUNCT3_SLL,
                            pick_reg(), OPCODE_IMM};
                // LUI
                default: instr = {20'($urandom), pick_reg(), 7'b0110111};
            endcase
        end
        return instr;
    endfunction

    task automatic hold_reset();
        int i;
        for (i = 0; i < 16; i++) begin
            @(posedge clk);
            // First edge still shows the pre-reset state
            if (i > 0) begin
                assert (!imem_req_valid && !commit_valid)
                    else report_failure("request or commit raised during reset");
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        assert (!imem_req_valid && !commit_valid)
            else report_failure("request or commit raised in the first cycle after reset");
    endtask

    task automatic check_stalled(input word_t addr);
        assert (imem_req_valid) else report_failure("request dropped while stalled");
        assert (imem_req.addr == addr)
            else report_failure($sformatf("FAILED o_imem_req.addr: got %h expected %h",
                imem_req.addr, addr));
    endtask

    // Memory side of the request handshake, with a random ready stall
    task automatic accept_request(output word_t addr);
        int stall;
        int waited;
        int i;
        stall = $urandom_range(0, 3);
        imem_req_ready <= (stall == 0);
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("no instruction request raised in time");
            end
        end while (!imem_req_valid);
        addr = imem_req.addr;
        if (stall != 0) begin
            for (i = 1; i < stall; i++) begin
                @(posedge clk);
                check_stalled(addr);
            end
            imem_req_ready <= 1'b1;
            @(posedge clk);
            check_stalled(addr);
        end
        imem_req_ready <= 1'b0;
    endtask

    // Delay 1 means the cycle right after acceptance
    task automatic send_response(input word_t instr);
        int delay;
        int i;
        delay = $urandom_range(1, 4);
        for (i = 1; i < delay; i++) begin
            @(posedge clk);
        end
        imem_rsp_valid <= 1'b1;
        imem_rsp       <= '{data: instr};
        @(posedge clk);
        imem_rsp_valid <= 1'b0;
    endtask

    // Compares each commit against the reference, 3 cycles after its response
    always @(posedge clk) begin
        if (!reset) begin
            if (commit_valid) begin
                assert (pending)
                    else report_failure("commit seen with no legal instruction pending");
                assert (cycle_count == due_cycle)
                    else report_failure($sformatf("FAILED o_commit_valid: cycle %h expected %h",
                        cycle_count, due_cycle));
                assert (commit.pc == expected.commit.pc)
                    else report_failure($sformatf("FAILED o_commit.pc: got %h expected %h",
                        commit.pc, expected.commit.pc));
                assert (commit.rd == expected.commit.rd)
                    else report_failure($sformatf("FAILED o_commit.rd: got %h expected %h",
                        commit.rd, expected.commit.rd));
                assert (commit.data == expected.commit.data)
                    else report_failure($sformatf("FAILED o_commit.data: got %h expected %h",
                        commit.data, expected.commit.data));
                pending = 1'b0;
                commit_count++;
            end else begin
                assert (!pending || cycle_count < due_cycle)
                    else report_failure("expected commit missing three cycles after its response");
            end
            if (imem_rsp_valid) begin
                served    = fetch_q.pop_front();
                expected  = ref_execute(served.instr, served.pc);
                pending   = expected.legal;
                due_cycle = cycle_count + 3;
            end
            cycle_count++;
        end
    end

    initial begin : main_seq
        int unsigned seed_discard;
        word_t       addr;
        word_t       last_addr;
        word_t       instr;
        int          n;
        int          waited;
        seed_discard   = $urandom(32'h22b7_8e2a);
        reset          = 1'b1;
        imem_req_ready = 1'b0;
        imem_rsp_valid = 1'b0;
        imem_rsp       = '0;
        last_addr      = '0;
        clear_ref_regs();
        hold_reset();

        for (n = 0; n < INSTR_COUNT; n++) begin
            accept_request(addr);
            // Sequential fetch, illegal encodings included
            if (n == 0) begin
                assert (addr == RESET_PC)
                    else report_failure($sformatf("FAILED o_imem_req.addr: got %h expected %h",
                        addr, RESET_PC));
            end else begin
                assert (addr == last_addr + 32'd4)
                    else report_failure($sformatf("FAILED o_imem_req.addr: got %h expected %h",
                        addr, last_addr + 32'd4));
            end
            last_addr = addr;
            instr     = make_instr();
            fetch_q.push_back('{pc: addr, instr: instr});
            send_response(instr);
        end

        // Next request shows the last instruction through WRITEBACK
        waited = 0;
        while (!imem_req_valid) begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_failure("last instruction never retired");
            end
        end
        $display("%0d instructions fetched, %0d commits checked", INSTR_COUNT, commit_count);
        if (commit_count > 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure("no instruction committed during the run");
        end
    end

endmodule

/* build.f */
+incdir+testbench
src/rv_core_pkg.sv
src/fetch_unit.sv
src/instr_decoder.sv
src/register_file.sv
src/alu.sv
src/rv_core.sv
testbench/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f build.f --Mdir obj_dir -o tb_rv_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/tb_rv_core_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Done: errors found" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
echo "Simulation passed"
exit 0
